//--- verilog/irq_pkg.sv
// Interrupt and sleep definitions

package irq_pkg;

  // ----------------------------------------------------------
  // Interrupt line constants
  // ----------------------------------------------------------

  // Number of external interrupt lines
  localparam int unsigned NUM_IRQ = 32;

  // Implemented lines 31..16, 11, 7 and 3; all others are reserved
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // ----------------------------------------------------------
  // Sleep constants
  // ----------------------------------------------------------

  // Cycles a WFI must already sit in writeback before sleep
  localparam int unsigned WFI_SLEEP_DELAY = 2;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------

  // One bit per interrupt line
  typedef logic [NUM_IRQ-1:0] irq_vec_t;

  // Interrupt number
  typedef logic [4:0] irq_id_t;

  // Privilege level, encoded as in the mstatus MPP field
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Sampled interrupt state shared by arbiter and sleep control
  typedef struct packed {
    // Machine interrupt pending, reserved lines cleared
    irq_vec_t mip;
    // Pending and locally enabled
    irq_vec_t pending;
  } irq_status_t;

  // Interrupt selected for the core
  typedef struct packed {
    logic    valid;
    irq_id_t id;
  } irq_grant_t;

endpackage

//--- verilog/irq_sampler.sv
// Interrupt line sampler

`timescale 1ns/1ps

module irq_sampler
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  irq_vec_t    irq_i,
  input  irq_vec_t    mie_i,
  output irq_status_t status_o
);

  // ----------------------------------------------------------
  // Pending register
  // ----------------------------------------------------------

  irq_vec_t mip_d;
  irq_vec_t mip_q;

  // Reserved lines never reach the pending register
  assign mip_d = irq_i & VALID_IRQ_MASK;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= mip_d;
    end
  end

  // ----------------------------------------------------------
  // Status output
  // ----------------------------------------------------------

  // mie follows without a register stage
  always_comb begin
    status_o.mip     = mip_q;
    status_o.pending = mip_q & mie_i;
  end

endmodule

//--- verilog/irq_arbiter.sv
// Fixed priority interrupt arbiter

`timescale 1ns/1ps

module irq_arbiter
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  irq_status_t status_i,
  input  logic        mstatus_mie_i,
  input  priv_lvl_e   priv_lvl_i,
  output irq_grant_t  grant_o
);

  // ----------------------------------------------------------
  // Priority selection
  // ----------------------------------------------------------

  irq_vec_t pend;
  logic     sel_valid;
  irq_id_t  sel_id;

  assign pend = status_i.pending;

  // Order from highest: 31 down to 16, then 11, then 3, then 7.
  // Lines are visited from the lowest priority upward so that
  // the last hit is the winner
  always_comb begin
    sel_valid = 1'b0;
    sel_id    = '0;

    // Lowest of the standard lines
    if (pend[7]) begin
      sel_valid = 1'b1;
      sel_id    = irq_id_t'(7);
    end

    // Software interrupt beats timer
    if (pend[3]) begin
      sel_valid = 1'b1;
      sel_id    = irq_id_t'(3);
    end

    // External interrupt
    if (pend[11]) begin
      sel_valid = 1'b1;
      sel_id    = irq_id_t'(11);
    end

    // Platform lines, higher number wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend[i]) begin
        sel_valid = 1'b1;
        sel_id    = irq_id_t'(i);
      end
    end
  end

  // ----------------------------------------------------------
  // Global enable
  // ----------------------------------------------------------

  logic glb_en;

  // In user mode any pending enabled line may trap to machine mode
  always_comb begin
    case (priv_lvl_i)
      PRIV_LVL_M: glb_en = mstatus_mie_i;
      PRIV_LVL_U: glb_en = |pend;
      default:    glb_en = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Grant register
  // ----------------------------------------------------------

  irq_grant_t grant_d;
  irq_grant_t grant_q;

  always_comb begin
    grant_d.valid = sel_valid & glb_en;
    grant_d.id    = sel_id;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      grant_q <= '0;
    end else begin
      grant_q <= grant_d;
    end
  end

  assign grant_o = grant_q;

endmodule

//--- verilog/wfi_sleep_ctrl.sv
// WFI sleep controller

`timescale 1ns/1ps

module wfi_sleep_ctrl
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  irq_status_t status_i,
  input  logic        wfi_i,
  input  logic        pipe_idle_i,
  input  logic        debug_req_i,
  output logic        core_sleep_o
);

  // ----------------------------------------------------------
  // WFI residency history
  // ----------------------------------------------------------

  // Bit k set means WFI was in writeback k+1 cycles ago
  logic [WFI_SLEEP_DELAY-1:0] wfi_hist_d;
  logic [WFI_SLEEP_DELAY-1:0] wfi_hist_q;
  logic                       wfi_resident;

  always_comb begin
    wfi_hist_d    = wfi_hist_q << 1;
    wfi_hist_d[0] = wfi_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wfi_hist_q <= '0;
    end else begin
      wfi_hist_q <= wfi_hist_d;
    end
  end

  // WFI has sat in writeback for the full delay already
  assign wfi_resident = &wfi_hist_q;

  // ----------------------------------------------------------
  // Wake and sleep conditions
  // ----------------------------------------------------------

  logic wake;
  logic sleep_d;
  logic sleep_q;

  // Masked interrupts still wake the core, so mstatus is ignored
  assign wake = (|status_i.pending) | debug_req_i;

  // Sleep only while WFI stays put and nothing is in flight
  always_comb begin
    sleep_d = 1'b0;
    if (wfi_resident && wfi_i && pipe_idle_i && !wake) begin
      sleep_d = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Sleep register
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else begin
      sleep_q <= sleep_d;
    end
  end

  assign core_sleep_o = sleep_q;

endmodule

//--- verilog/irq_sleep_top.sv
// Interrupt front end and sleep top

`timescale 1ns/1ps

module irq_sleep_top
  import irq_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Interrupt lines and CSR state
  input  irq_vec_t   irq_i,
  input  irq_vec_t   mie_i,
  input  logic       mstatus_mie_i,
  input  priv_lvl_e  priv_lvl_i,

  // Writeback and pipeline state
  input  logic       wfi_i,
  input  logic       pipe_idle_i,
  input  logic       debug_req_i,

  // Results
  output irq_vec_t   mip_o,
  output irq_grant_t grant_o,
  output logic       core_sleep_o
);

  // ----------------------------------------------------------
  // Interrupt status
  // ----------------------------------------------------------

  irq_status_t status;

  irq_sampler irq_sampler_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .irq_i    (irq_i),
    .mie_i    (mie_i),
    .status_o (status)
  );

  assign mip_o = status.mip;

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------

  irq_arbiter irq_arbiter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .status_i      (status),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .grant_o       (grant_o)
  );

  // ----------------------------------------------------------
  // Sleep control
  // ----------------------------------------------------------

  wfi_sleep_ctrl wfi_sleep_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .status_i     (status),
    .wfi_i        (wfi_i),
    .pipe_idle_i  (pipe_idle_i),
    .debug_req_i  (debug_req_i),
    .core_sleep_o (core_sleep_o)
  );

endmodule

//--- sim/tb_irq_sleep_checks.svh
// Testbench checks and reporting

`ifndef TB_IRQ_SLEEP_CHECKS_SVH
`define TB_IRQ_SLEEP_CHECKS_SVH

// ----------------------------------------------------------
// Failure handling
// ----------------------------------------------------------

// Print the problem, then end the run at once
task automatic abort_run(input string msg);
  $display("%s", msg);
  $display("TESTBENCH FAILED");
  $fatal(1, "run stopped at first failed check");
endtask

// ----------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------

task automatic check_vec(input string name, input irq_vec_t act, input irq_vec_t exp);
  if (act !== exp) begin
    abort_run($sformatf("error at time %0t: %s expected %h, got %h",
                        $time, name, exp, act));
  end
endtask

// Id only matters while the grant is valid
task automatic check_grant(input string name, input irq_grant_t act,
                           input irq_grant_t exp);
  logic bad;
  bad = (act.valid !== exp.valid) || (exp.valid && (act.id !== exp.id));
  if (bad) begin
    abort_run($sformatf("error at time %0t: %s expected valid %b id %0d, got valid %b id %0d",
                        $time, name, exp.valid, exp.id, act.valid, act.id));
  end
endtask

task automatic check_sleep(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    abort_run($sformatf("error at time %0t: %s expected %b, got %b",
                        $time, name, exp, act));
  end
endtask

// ----------------------------------------------------------
// Waits
// ----------------------------------------------------------

// Sample mid-cycle until the sleep level matches or time runs out
task automatic wait_for_sleep(input logic level, input int max_cycles);
  int cycles;
  cycles = 0;
  @(negedge clk_i);
  while (core_sleep_o !== level) begin
    if (cycles >= max_cycles) begin
      abort_run($sformatf("core_sleep_o did not become %b within %0d cycles",
                          level, max_cycles));
    end
    @(negedge clk_i);
    cycles++;
  end
endtask

`endif

//--- sim/tb_irq_sleep_top.sv
// Interrupt and sleep testbench

`timescale 1ns/1ps

module tb_irq_sleep_top
  import irq_pkg::*;
();

  localparam int CLK_HALF     = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 5;
  localparam int ROW_CYCLES   = 4;
  localparam int NUM_DIRECTED = 16;
  localparam int NUM_RANDOM   = 40;
  localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;

  // ----------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------

  logic       clk_i;
  logic       rst_ni;
  irq_vec_t   irq_i;
  irq_vec_t   mie_i;
  logic       mstatus_mie_i;
  priv_lvl_e  priv_lvl_i;
  logic       wfi_i;
  logic       pipe_idle_i;
  logic       debug_req_i;
  irq_vec_t   mip_o;
  irq_grant_t grant_o;
  logic       core_sleep_o;

  // One stimulus row with its expected results
  typedef struct packed {
    irq_vec_t   irq;
    irq_vec_t   mie;
    logic       mstatus_mie;
    priv_lvl_e  priv;
    logic       wfi;
    logic       pipe_idle;
    logic       debug_req;
    irq_vec_t   exp_mip;
    irq_grant_t exp_grant;
    logic       exp_sleep;
  } stim_row_t;

  stim_row_t   rows [NUM_ROWS];
  logic [31:0] lfsr_state;

  `include "tb_irq_sleep_checks.svh"

  always #CLK_HALF clk_i = ~clk_i;

  irq_sleep_top irq_sleep_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .wfi_i         (wfi_i),
    .pipe_idle_i   (pipe_idle_i),
    .debug_req_i   (debug_req_i),
    .mip_o         (mip_o),
    .grant_o       (grant_o),
    .core_sleep_o  (core_sleep_o)
  );

  // ----------------------------------------------------------
  // Random source and reference model
  // ----------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  function automatic stim_row_t make_row(
    input irq_vec_t irq, input irq_vec_t mie, input logic mst, input priv_lvl_e priv,
    input logic wfi, input logic idle, input logic dbg, input irq_vec_t exp_mip,
    input logic exp_valid, input irq_id_t exp_id, input logic exp_sleep);
    stim_row_t r;
    r.irq             = irq;
    r.mie             = mie;
    r.mstatus_mie     = mst;
    r.priv            = priv;
    r.wfi             = wfi;
    r.pipe_idle       = idle;
    r.debug_req       = dbg;
    r.exp_mip         = exp_mip;
    r.exp_grant.valid = exp_valid;
    r.exp_grant.id    = exp_id;
    r.exp_sleep       = exp_sleep;
    return r;
  endfunction

  // Expected results after a row has been held for its full length
  function automatic stim_row_t expect_row(input stim_row_t r);
    stim_row_t e;
    irq_vec_t  mask;
    irq_vec_t  pend;
    int        line;
    logic      found;
    logic      glb;
    e    = r;
    mask = '0;
    for (int b = 16; b < 32; b++) begin
      mask[b] = 1'b1;
    end
    mask[11] = 1'b1;
    mask[7]  = 1'b1;
    mask[3]  = 1'b1;
    e.exp_mip   = r.irq & mask;
    pend        = e.exp_mip & r.mie;
    found       = 1'b0;
    e.exp_grant = '0;
    // Walk the priority list from the top, first hit wins
    for (int k = 0; k < 19; k++) begin
      if (k < 16) line = 31 - k;
      else if (k == 16) line = 11;
      else if (k == 17) line = 3;
      else line = 7;
      if (!found && pend[line]) begin
        found          = 1'b1;
        e.exp_grant.id = irq_id_t'(line);
      end
    end
    glb = (r.priv == PRIV_LVL_M) ? r.mstatus_mie : found;
    e.exp_grant.valid = found && glb;
    e.exp_sleep = r.wfi && r.pipe_idle && !r.debug_req && (pend == '0);
    return e;
  endfunction

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------

  task automatic load_table();
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [31:0] b_mst;
    logic [31:0] b_priv;
    logic [31:0] b_wfi;
    stim_row_t   r;
    // Masking of reserved lines
    rows[0]  = make_row(32'h0, 32'h0, 0, PRIV_LVL_M, 0, 1, 0, 32'h0, 0, 0, 0);
    rows[1]  = make_row(32'h00001021, 32'hffffffff, 1, PRIV_LVL_M, 0, 1, 0,
                        32'h0, 0, 0, 0);
    rows[2]  = make_row(32'hffffffff, 32'h0, 1, PRIV_LVL_M, 0, 1, 0,
                        32'hffff0888, 0, 0, 0);
    // Priority order
    rows[3]  = make_row(32'h00000888, 32'hffffffff, 1, PRIV_LVL_M, 0, 1, 0,
                        32'h00000888, 1, 11, 0);
    rows[4]  = make_row(32'h00000088, 32'hffffffff, 1, PRIV_LVL_M, 0, 1, 0,
                        32'h00000088, 1, 3, 0);
    rows[5]  = make_row(32'h80010888, 32'h00010888, 1, PRIV_LVL_M, 0, 1, 0,
                        32'h80010888, 1, 16, 0);
    rows[6]  = make_row(32'h00000080, 32'hffffffff, 1, PRIV_LVL_M, 0, 1, 0,
                        32'h00000080, 1, 7, 0);
    // Global enable in machine and user mode
    rows[7]  = make_row(32'h00400800, 32'hffffffff, 0, PRIV_LVL_M, 0, 1, 0,
                        32'h00400800, 0, 0, 0);
    rows[8]  = make_row(32'h00400800, 32'hffffffff, 0, PRIV_LVL_U, 0, 1, 0,
                        32'h00400800, 1, 22, 0);
    // Sleep entry, busy pipeline, debug and interrupt wake
    rows[9]  = make_row(32'h0, 32'hffffffff, 1, PRIV_LVL_M, 1, 1, 0, 32'h0, 0, 0, 1);
    rows[10] = make_row(32'h0, 32'hffffffff, 1, PRIV_LVL_M, 1, 0, 0, 32'h0, 0, 0, 0);
    rows[11] = make_row(32'h0, 32'hffffffff, 1, PRIV_LVL_M, 1, 1, 0, 32'h0, 0, 0, 1);
    rows[12] = make_row(32'h0, 32'hffffffff, 1, PRIV_LVL_M, 1, 1, 1, 32'h0, 0, 0, 0);
    rows[13] = make_row(32'h0, 32'hffffffff, 1, PRIV_LVL_M, 1, 1, 0, 32'h0, 0, 0, 1);
    rows[14] = make_row(32'h00000008, 32'hffffffff, 0, PRIV_LVL_M, 1, 1, 0,
                        32'h00000008, 0, 0, 0);
    rows[15] = make_row(32'h0, 32'hffffffff, 1, PRIV_LVL_M, 0, 1, 0, 32'h0, 0, 0, 0);
    // Random rows with sparse lines so that lower priorities also win
    for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
      take_bits(32, w1);
      take_bits(32, w2);
      take_bits(32, w3);
      take_bits(1, b_mst);
      take_bits(1, b_priv);
      take_bits(1, b_wfi);
      r = make_row(w1 & w2, w3, b_mst[0], b_priv[0] ? PRIV_LVL_M : PRIV_LVL_U,
                   b_wfi[0], 1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
      rows[i] = expect_row(r);
    end
  endtask

  task automatic apply_row(input stim_row_t r);
    irq_i         = r.irq;
    mie_i         = r.mie;
    mstatus_mie_i = r.mstatus_mie;
    priv_lvl_i    = r.priv;
    wfi_i         = r.wfi;
    pipe_idle_i   = r.pipe_idle;
    debug_req_i   = r.debug_req;
  endtask

  // ----------------------------------------------------------
  // Cycle exact sleep entry and wake
  // ----------------------------------------------------------

  task automatic run_sleep_sequence();
    @(posedge clk_i);
    #DRIVE_DELAY;
    apply_row(make_row(32'h0, 32'h0, 0, PRIV_LVL_M, 0, 1, 0, 32'h0, 0, 0, 0));
    repeat (2) @(posedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    wfi_i = 1'b1;
    // Low for three cycles of WFI, high from the fourth
    for (int c = 1; c <= 4; c++) begin
      @(negedge clk_i);
      check_sleep("core_sleep_o", core_sleep_o, c == 4);
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    debug_req_i = 1'b1;
    @(negedge clk_i);
    check_sleep("core_sleep_o", core_sleep_o, 1'b1);
    @(negedge clk_i);
    check_sleep("core_sleep_o", core_sleep_o, 1'b0);
    @(posedge clk_i);
    #DRIVE_DELAY;
    debug_req_i = 1'b0;
    wait_for_sleep(1'b1, 4);
    // Line 16 pending but not enabled keeps the core asleep
    @(posedge clk_i);
    #DRIVE_DELAY;
    irq_i = 32'h00010000;
    repeat (2) begin
      @(negedge clk_i);
      check_sleep("core_sleep_o", core_sleep_o, 1'b1);
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    mie_i = 32'h00010000;
    @(negedge clk_i);
    check_sleep("core_sleep_o", core_sleep_o, 1'b1);
    @(negedge clk_i);
    check_sleep("core_sleep_o", core_sleep_o, 1'b0);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    irq_i         = '0;
    mie_i         = '0;
    mstatus_mie_i = 1'b0;
    priv_lvl_i    = PRIV_LVL_M;
    wfi_i         = 1'b0;
    pipe_idle_i   = 1'b0;
    debug_req_i   = 1'b0;
    lfsr_state    = 32'h3b10;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_vec("mip_o", mip_o, '0);
    check_grant("grant_o", grant_o, '0);
    check_sleep("core_sleep_o", core_sleep_o, 1'b0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      apply_row(rows[i]);
      repeat (ROW_CYCLES - 1) @(posedge clk_i);
      @(negedge clk_i);
      check_vec("mip_o", mip_o, rows[i].exp_mip);
      check_grant("grant_o", grant_o, rows[i].exp_grant);
      check_sleep("core_sleep_o", core_sleep_o, rows[i].exp_sleep);
    end
    run_sleep_sequence();
    @(posedge clk_i);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+sim
verilog/irq_pkg.sv
verilog/irq_sampler.sv
verilog/irq_arbiter.sv
verilog/wfi_sleep_ctrl.sv
verilog/irq_sleep_top.sv
sim/tb_irq_sleep_top.sv
